//--- bench/sha3_assert.sv
`timescale 1ns/1ps
`default_nettype none

module sha3_assert (
	input logic clk,
	input logic rst,
	input logic absorb_valid,
	input logic buffer_full,
	input logic out_valid,
	input logic dout_valid,
	input logic done,
	input logic continue_perm
);

	// no lane offered while the core holds a block
	no_lane_when_full: assert property (@(posedge clk) disable iff (rst)
		!(absorb_valid && buffer_full)) else $error("absorb_valid high with buffer_full");

	// output samples only from core words once absorbing is over
	out_needs_core: assert property (@(posedge clk) disable iff (rst)
		out_valid |-> dout_valid && !absorb_valid)
		else $error("out_valid without core output or while absorbing");

	done_one_cycle: assert property (@(posedge clk) disable iff (rst)
		done |=> !done) else $error("done held longer than one cycle");

	perm_one_cycle: assert property (@(posedge clk) disable iff (rst)
		continue_perm |=> !continue_perm) else $error("continue_perm held longer than one cycle");

endmodule

bind sha3_wrapper_top sha3_assert assert_i (
	.clk, .rst, .absorb_valid, .buffer_full, .out_valid, .dout_valid, .done, .continue_perm
);

`default_nettype wire

//--- bench/sha3_tb.sv
`timescale 1ns/1ps
`default_nettype none

module sha3_tb;
	import sha3_pkg::*;

	logic      clk, rst, start, busy, done;
	logic      absorb_valid, buffer_full, last_block, dout_valid, ready;
	logic      continue_perm, out_valid;
	len_t      mlen, olen;
	rate_sel_t rate_type;
	addr_t     rd_addr, wt_addr, prev_addr;
	lane_t     rd_data, absorb_lane, core_dout, out_data;

	lane_t mem [512];
	lane_t words [$];        // core output words in emission order
	int    rate, exp_abs, exp_out, exp_cp;
	int    n_abs, n_out, n_cp, cyc;
	int    bf_left, sq_delay, sq_left;
	logic  raise_bf, saw_last, cp_last, msg_over;

	sha3_wrapper_top dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk)
		rd_data <= mem[rd_addr]; // read port with one cycle latency

	task automatic stop_run();
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input lane_t got, input lane_t exp);
		$display("FAIL %0t %s: got %h, expected %h", $time, name, got, exp);
		stop_run();
	endtask

	task automatic report_failure(input string what);
		$display("error at %0t: %s", $time, what);
		stop_run();
	endtask

	// padded lane k from data, tail bytes, separator, zeros and closing bit
	function automatic lane_t padded_lane(input int k);
		lane_t lane;
		int    full;
		int    tail;
		full = int'(mlen) / 8;
		tail = int'(mlen) % 8;
		lane = '0;
		if (k < full)
			lane = mem[k];
		else if (k == full) begin
			for (int i = 0; i < tail; i++)
				lane[8*i +: 8] = mem[k][8*i +: 8];
			lane[8*tail +: 8] = (rate_type == 2'd2) ? 8'h1f : 8'h06;
		end
		if (k == exp_abs - 1)
			lane[63] = 1'b1; // last lane of the final block
		return lane;
	endfunction

	// sampled at posedge with pre-edge values
	task automatic check_outputs();
		logic exp_ov;
		if (absorb_valid) begin
			assert (!buffer_full) else report_failure("lane offered while buffer_full high");
			assert (n_abs < exp_abs) else report_mismatch("absorbed lanes", n_abs + 1, exp_abs);
			assert (absorb_lane == padded_lane(n_abs))
				else report_mismatch("absorb_lane", absorb_lane, padded_lane(n_abs));
			n_abs++;
			raise_bf = (n_abs % rate == 0); // block handed over
		end
		if (last_block) begin
			assert (n_abs == exp_abs) else report_mismatch("lanes at last_block", n_abs, exp_abs);
			saw_last = 1'b1;
		end
		if (cyc == 0) begin
			assert (!done) else report_failure("done held longer than one cycle");
		end else if (cyc == 1) begin
			assert (rd_addr == '0) else report_mismatch("rd_addr", rd_addr, 0);
		end else begin
			assert (rd_addr >= prev_addr) else report_mismatch("rd_addr", rd_addr, prev_addr);
		end
		prev_addr = rd_addr;
		// idle before the start edge and again in the done cycle
		if (cyc == 0 || done) begin
			assert (!busy) else report_mismatch("busy", busy, 1'b0);
		end else begin
			assert (busy) else report_mismatch("busy", busy, 1'b1);
		end
		exp_ov = dout_valid && ready && (n_out < exp_out); // core word while output remains
		assert (out_valid == exp_ov) else report_mismatch("out_valid", out_valid, exp_ov);
		if (out_valid) begin
			assert (out_data == words[n_out]) else report_mismatch("out_data", out_data, words[n_out]);
			assert (wt_addr == addr_t'(n_out)) else report_mismatch("wt_addr", wt_addr, n_out);
			n_out++;
		end
		assert (!(continue_perm && cp_last)) else report_failure("continue_perm longer than a cycle");
		cp_last = continue_perm;
		if (continue_perm) begin
			n_cp++;
			sq_delay = $urandom_range(12, 1); // next permutation latency
		end
		if (done) begin
			assert (n_out == exp_out) else report_mismatch("output samples", n_out, exp_out);
			assert (n_cp == exp_cp) else report_mismatch("continue_perm pulses", n_cp, exp_cp);
			assert (n_abs == exp_abs) else report_mismatch("absorbed lanes", n_abs, exp_abs);
			assert (int'(rd_addr) + 1 >= (int'(mlen) + 7) / 8)
				else report_mismatch("words read", rd_addr + 1, (mlen + 7) / 8);
			msg_over = 1'b1;
		end
	endtask

	// keccak core model driven at negedge
	task automatic drive_core();
		if (raise_bf) begin
			buffer_full = 1'b1;
			bf_left     = $urandom_range(20, 1);
			raise_bf    = 1'b0;
		end else if (buffer_full) begin
			bf_left--;
			if (bf_left == 0) begin
				buffer_full = 1'b0; // permutation over
				if (saw_last)
					sq_delay = $urandom_range(12, 1);
			end
		end
		if (sq_delay > 0) begin
			sq_delay--;
			if (sq_delay == 0)
				sq_left = rate; // one block of output words
		end
		dout_valid = (sq_left > 0);
		ready      = dout_valid;
		if (sq_left > 0) begin
			core_dout = {$urandom, $urandom};
			words.push_back(core_dout);
			sq_left--;
		end
	endtask

	task automatic run_message();
		mlen      = $urandom_range(400, 0);
		olen      = $urandom_range(600, 1);
		rate_type = $urandom_range(2, 0);
		rate      = (rate_type == 2'd0) ? 9 : (rate_type == 2'd1) ? 17 : 21;
		foreach (mem[a])
			mem[a] = {$urandom, $urandom};
		exp_abs  = ((int'(mlen) / 8 + rate) / rate) * rate; // lanes up to the pad in whole blocks
		exp_out  = (int'(olen) + 7) / 8;
		exp_cp   = (exp_out + rate - 1) / rate - 1;
		n_abs    = 0;
		n_out    = 0;
		n_cp     = 0;
		cyc      = 0;
		saw_last = 1'b0;
		msg_over = 1'b0;
		words.delete();
		start = 1'b1;
		while (!msg_over) begin
			@(posedge clk);
			check_outputs();
			@(negedge clk);
			start = 1'b0;
			drive_core();
			cyc++;
			if (cyc > 5000)
				report_failure("no done within 5000 cycles");
		end
	endtask

	initial begin
		void'($urandom(32'h2b8e60f1));
		rst         = 1'b1;
		start       = 1'b0;
		mlen        = '0;
		olen        = '0;
		rate_type   = '0;
		rd_data     = '0;
		buffer_full = 1'b0;
		core_dout   = '0;
		dout_valid  = 1'b0;
		ready       = 1'b0;
		raise_bf    = 1'b0;
		cp_last     = 1'b0;
		sq_delay    = 0;
		sq_left     = 0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		assert (!absorb_valid && !last_block && !continue_perm && !out_valid && !done &&
			rd_addr == '0 && wt_addr == '0) else report_failure("outputs not cleared by reset");
		rst = 1'b0;
		for (int m = 0; m < 30; m++)
			run_message();
		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- logic/absorb_counter.sv
`timescale 1ns/1ps
`default_nettype none

module absorb_counter (
	input  logic                clk,
	input  logic                rst,
	input  logic                load,       // start accepted
	input  logic                inc_lane,   // step lane position, wraps at block end
	input  logic                dec_msg,    // one full lane consumed
	input  logic                inc_addr,   // next memory word
	input  sha3_pkg::len_t      mlen,
	input  sha3_pkg::rate_sel_t rate_type,
	output sha3_pkg::addr_t     rd_addr,
	output logic                msg_tail,   // under 8 bytes left
	output logic                block_end,  // current lane is the last of the block
	output logic [2:0]          tail_bytes  // valid bytes in the tail lane
);
	import sha3_pkg::*;

	len_t      msg_left; // bytes still to absorb, counted per lane
	lane_cnt_t lane_pos; // 1 based, matches the lane on absorb_lane
	lane_cnt_t rate;     // captured lanes per block

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			msg_left <= '0;
			rate     <= rate_lanes_576;
		end else if (load) begin
			msg_left <= mlen;
			rate     <= rate_lanes_of(rate_type);
		end else if (dec_msg) begin
			msg_left <= msg_left - len_t'(lane_bytes); // fsm holds off below 8
		end
	end

	// lane position inside the block
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			lane_pos <= 8'd1;
		end else if (load) begin
			lane_pos <= 8'd1;
		end else if (inc_lane) begin
			if (block_end)
				lane_pos <= 8'd1; // first lane of next block
			else
				lane_pos <= lane_pos + 8'd1;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			rd_addr <= '0;
		else if (load)
			rd_addr <= '0; // each message starts at word 0
		else if (inc_addr)
			rd_addr <= rd_addr + addr_t'(1);
	end

	assign msg_tail   = (msg_left < len_t'(lane_bytes));
	assign block_end  = (lane_pos == rate);
	assign tail_bytes = msg_left[2:0];

endmodule

`default_nettype wire

//--- logic/lane_padder.sv
`timescale 1ns/1ps
`default_nettype none

module lane_padder (
	input  logic                clk,
	input  logic                rst,
	input  logic                load,
	input  sha3_pkg::rate_sel_t rate_type,
	input  sha3_pkg::lane_t     rd_data,     // memory word one cycle after its address
	input  logic                msg_tail,
	input  logic                block_end,
	input  logic [2:0]          tail_bytes,
	output sha3_pkg::lane_t     absorb_lane
);
	import sha3_pkg::*;

	byte_t sep;         // separator of the running message
	logic  sep_pending; // separator byte still to be placed
	logic  load_d;      // high in first_read where the tail flag is ahead of the data
	lane_t lane;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			sep         <= sep_sha3;
			sep_pending <= 1'b0;
			load_d      <= 1'b0;
		end else begin
			load_d <= load;
			if (load) begin
				sep         <= sep_of(rate_type);
				sep_pending <= 1'b1;
			end else if (msg_tail && !load_d) begin
				sep_pending <= 1'b0; // tail lane is on absorb_lane now
			end
		end
	end

	// per byte mux over data, separator and zero
	always_comb begin
		for (int i = 0; i < lane_bytes; i++) begin
			if (!msg_tail || (sep_pending && (i < int'(tail_bytes))))
				lane[8*i +: 8] = rd_data[8*i +: 8];       // full lane or last message bytes
			else if (sep_pending && (i == int'(tail_bytes)))
				lane[8*i +: 8] = sep;
			else
				lane[8*i +: 8] = 8'h00;                   // zero fill
		end
		// closing pad bit on the last lane of the final block
		if (block_end && msg_tail)
			lane[63] = 1'b1;
	end

	assign absorb_lane = lane;

endmodule

`default_nettype wire

//--- logic/sha3_pkg.sv
`default_nettype none

package sha3_pkg;

	typedef logic [63:0] lane_t;     // one keccak lane or one memory word
	typedef logic [7:0]  byte_t;
	typedef logic [31:0] len_t;      // byte count for mlen and olen
	typedef logic [8:0]  addr_t;     // memory word address
	typedef logic [7:0]  lane_cnt_t; // lane position inside a block
	typedef logic [1:0]  rate_sel_t; // 0 is r=576, 1 is r=1088, 2 is r=1344

	localparam int lane_bytes = 8;

	// lanes per block
	localparam lane_cnt_t rate_lanes_576  = 8'd9;
	localparam lane_cnt_t rate_lanes_1088 = 8'd17;
	localparam lane_cnt_t rate_lanes_1344 = 8'd21;

	// domain separation bytes
	localparam byte_t sep_sha3  = 8'h06;
	localparam byte_t sep_shake = 8'h1f;

	typedef enum logic [3:0] {
		idle,
		first_read,  // address 0 on the memory bus
		absorb,      // one padded lane per cycle
		block_wait,  // wait for buffer_full to rise
		refill,      // wait for buffer_full to fall, reissue next address
		final_wait,  // last block handed over, wait for output
		squeeze,     // core output burst
		squeeze_end,
		permute,     // request one more permutation
		perm_wait,
		finish
	} sponge_state_t;

	function automatic lane_cnt_t rate_lanes_of(input rate_sel_t sel);
		case (sel)
			2'd0:    return rate_lanes_576;
			2'd1:    return rate_lanes_1088;
			default: return rate_lanes_1344;
		endcase
	endfunction

	function automatic byte_t sep_of(input rate_sel_t sel);
		// only the 1344 rate runs as shake
		return (sel == 2'd2) ? sep_shake : sep_sha3;
	endfunction

endpackage

`default_nettype wire

//--- logic/sha3_wrapper_top.sv
`timescale 1ns/1ps
`default_nettype none

module sha3_wrapper_top (
	input  logic                clk,
	input  logic                rst,
	// run control
	input  logic                start,
	input  sha3_pkg::len_t      mlen,
	input  sha3_pkg::len_t      olen,
	input  sha3_pkg::rate_sel_t rate_type,
	output logic                busy,
	output logic                done,
	// message memory
	output sha3_pkg::addr_t     rd_addr,
	input  sha3_pkg::lane_t     rd_data,
	// keccak core, absorb side
	output sha3_pkg::lane_t     absorb_lane,
	output logic                absorb_valid,
	input  logic                buffer_full,
	output logic                last_block,
	// keccak core, squeeze side
	input  sha3_pkg::lane_t     core_dout,
	input  logic                dout_valid,
	input  logic                ready,
	output logic                continue_perm,
	// digest output
	output sha3_pkg::lane_t     out_data,
	output logic                out_valid,
	output sha3_pkg::addr_t     wt_addr
);

	logic       load;
	logic       inc_lane;
	logic       dec_msg;
	logic       inc_addr;
	logic       msg_tail;
	logic       block_end;
	logic [2:0] tail_bytes;
	logic       out_left;

	sponge_ctrl ctrl_i (
		.clk, .rst,
		.start, .buffer_full, .msg_tail, .block_end, .dout_valid, .out_left,
		.busy, .load, .inc_lane, .dec_msg, .inc_addr,
		.absorb_valid, .last_block, .continue_perm, .done
	);

	absorb_counter absorb_i (
		.clk, .rst,
		.load, .inc_lane, .dec_msg, .inc_addr,
		.mlen, .rate_type,
		.rd_addr, .msg_tail, .block_end, .tail_bytes
	);

	lane_padder padder_i (
		.clk, .rst, .load,
		.rate_type, .rd_data,
		.msg_tail, .block_end, .tail_bytes,
		.absorb_lane
	);

	squeeze_counter squeeze_i (
		.clk, .rst, .load,
		.olen, .dout_valid, .ready,
		.out_valid, .out_left, .wt_addr
	);

	assign out_data = core_dout; // qualified by out_valid

endmodule

`default_nettype wire

//--- logic/sponge_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module sponge_ctrl (
	input  logic clk,
	input  logic rst,
	input  logic start,
	input  logic buffer_full,  // core busy with a block
	input  logic msg_tail,
	input  logic block_end,
	input  logic dout_valid,
	input  logic out_left,
	output logic busy,
	output logic load,
	output logic inc_lane,
	output logic dec_msg,
	output logic inc_addr,
	output logic absorb_valid,
	output logic last_block,
	output logic continue_perm,
	output logic done
);
	import sha3_pkg::*;

	sponge_state_t state, next_state;
	logic lane_step; // lane position moves on

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			state <= idle;
		else
			state <= next_state;
	end

	always_comb begin
		next_state = state;
		case (state)
			idle:
				if (start)
					next_state = first_read;
			first_read:
				next_state = absorb; // word 0 arrives next cycle
			absorb:
				if (block_end)
					next_state = block_wait;
			block_wait:
				if (buffer_full) begin
					// tail already seen means this was the final block
					if (msg_tail)
						next_state = final_wait;
					else
						next_state = refill;
				end
			refill:
				if (!buffer_full)
					next_state = absorb;
			final_wait:
				if (dout_valid)
					next_state = squeeze;
			squeeze:
				if (!dout_valid)
					next_state = squeeze_end; // burst over
			squeeze_end:
				if (out_left)
					next_state = permute;
				else
					next_state = finish;
			permute:
				next_state = perm_wait;
			perm_wait:
				if (dout_valid)
					next_state = squeeze;
			finish:
				next_state = idle;
			default:
				next_state = idle;
		endcase
	end

	// block end lane is accounted in refill, once the core has taken the block
	assign lane_step = ((state == absorb) && !block_end) ||
	                   ((state == refill) && !buffer_full);

	assign load      = (state == idle) && start;
	assign busy      = (state != idle);
	assign inc_lane  = lane_step;
	assign dec_msg   = lane_step && !msg_tail; // count stops in the tail lane
	assign inc_addr  = (state == first_read) || (lane_step && !msg_tail);

	assign absorb_valid  = (state == absorb);
	assign last_block    = (state == final_wait) || ((state == block_wait) && msg_tail);
	assign continue_perm = (state == permute); // single cycle state

	// one cycle pulse after the last sample
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			done <= 1'b0;
		else
			done <= (state == finish);
	end

endmodule

`default_nettype wire

//--- logic/squeeze_counter.sv
`timescale 1ns/1ps
`default_nettype none

module squeeze_counter (
	input  logic            clk,
	input  logic            rst,
	input  logic            load,
	input  sha3_pkg::len_t  olen,
	input  logic            dout_valid,
	input  logic            ready,
	output logic            out_valid, // one output sample this cycle
	output logic            out_left,  // output bytes still owed
	output sha3_pkg::addr_t wt_addr
);
	import sha3_pkg::*;

	len_t out_rem; // bytes left to deliver

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			out_rem <= '0;
			wt_addr <= '0;
		end else if (load) begin
			out_rem <= olen;
			wt_addr <= '0;
		end else if (out_valid) begin
			// partial last word still counts as one sample
			if (out_rem > len_t'(lane_bytes))
				out_rem <= out_rem - len_t'(lane_bytes);
			else
				out_rem <= '0;
			wt_addr <= wt_addr + addr_t'(1);
		end
	end

	assign out_left  = (out_rem != '0);
	assign out_valid = dout_valid && ready && out_left; // extra core words are dropped

endmodule

`default_nettype wire

//--- verilog.f
logic/sha3_pkg.sv
logic/absorb_counter.sv
logic/lane_padder.sv
logic/squeeze_counter.sv
logic/sponge_ctrl.sv
logic/sha3_wrapper_top.sv
bench/sha3_assert.sv
bench/sha3_tb.sv
